// File: hw/ao_periph_pkg.sv
/*
 * Always-on peripheral package
 * Bus structs, address map, register offsets and power-manager states
 */
package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Region 0x2000_0000, one 4 KiB slot per peripheral
  localparam logic [15:0] AO_BASE_HI = 16'h2000;
  localparam int unsigned NUM_AO_PERIPH = 4;
  localparam int unsigned SLOT_WIDTH = 2;

  localparam logic [SLOT_WIDTH-1:0] SOC_CTRL_IDX = 2'd0;
  localparam logic [SLOT_WIDTH-1:0] TIMER_IDX = 2'd1;
  localparam logic [SLOT_WIDTH-1:0] POWER_MANAGER_IDX = 2'd2;
  localparam logic [SLOT_WIDTH-1:0] PAD_ATTRIBUTE_IDX = 2'd3;

  localparam logic [11:0] SOC_EXIT_VALID = 12'h000;
  localparam logic [11:0] SOC_EXIT_VALUE = 12'h004;
  localparam logic [11:0] SOC_BOOT_SEL = 12'h008;
  localparam logic [11:0] SOC_SCRATCH = 12'h00C;

  localparam logic [11:0] TMR_MTIME = 12'h000;
  localparam logic [11:0] TMR_MTIMECMP = 12'h004;
  localparam logic [11:0] TMR_CTRL = 12'h008;

  localparam logic [11:0] PM_CTRL = 12'h000;
  localparam logic [11:0] PM_STATUS = 12'h004;
  localparam logic [11:0] PM_WAKE_COUNT = 12'h008;

  localparam logic [11:0] PAD_ATTR_BASE = 12'h000;

  localparam int unsigned NUM_PAD = 4;
  localparam int unsigned RESTORE_CYCLES = 4;

  typedef enum logic [1:0] {
    PM_ACTIVE  = 2'd0,
    PM_ISOLATE = 2'd1,
    PM_OFF     = 2'd2,
    PM_RESTORE = 2'd3
  } pm_state_e;

  // Byte-lane merge of a register write
  function automatic logic [31:0] apply_strobe(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b+:8] = new_val[8*b+:8];
      end
    end
    return res;
  endfunction

endpackage

// File: hw/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem
 * OBI slave bridged to a register bus feeding four peripherals
 */
module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  obi_req_t                 slave_req_i,
  output obi_resp_t                slave_resp_o,
  input  logic                     boot_select_i,
  input  logic                     core_sleep_i,
  output logic                     exit_valid_o,
  output logic [31:0]              exit_value_o,
  output logic                     rv_timer_irq_timer_o,
  output logic                     cpu_subsystem_powergate_switch_o,
  output logic                     cpu_subsystem_rst_no,
  output logic [NUM_PAD-1:0][15:0] pad_attributes_o
);

  reg_req_t                     periph_req;
  reg_rsp_t                     periph_rsp;
  reg_req_t [NUM_AO_PERIPH-1:0] slv_req;
  reg_rsp_t [NUM_AO_PERIPH-1:0] slv_rsp;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .in_req_i (periph_req),
    .in_rsp_o (periph_rsp),
    .out_req_o(slv_req),
    .out_rsp_i(slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o(slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  // Timer interrupt also wakes the CPU domain
  ao_timer ao_timer_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i  (slv_req[TIMER_IDX]),
    .reg_rsp_o  (slv_rsp[TIMER_IDX]),
    .timer_irq_o(rv_timer_irq_timer_o)
  );

  power_manager power_manager_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i  (slv_req[POWER_MANAGER_IDX]),
    .reg_rsp_o  (slv_rsp[POWER_MANAGER_IDX]),
    .core_sleep_i,
    .timer_irq_i(rv_timer_irq_timer_o),
    .cpu_subsystem_powergate_switch_o,
    .cpu_subsystem_rst_no
  );

  pad_attribute pad_attribute_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(slv_req[PAD_ATTRIBUTE_IDX]),
    .reg_rsp_o(slv_rsp[PAD_ATTRIBUTE_IDX]),
    .pad_attributes_o
  );

endmodule

// File: hw/ao_timer.sv
/*
 * Machine timer
 * Free-running 32-bit counter with a registered compare interrupt
 */
module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     timer_irq_o
);

  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        enable_q;
  logic        irq_q;
  logic        wr;
  logic [11:0] offset;

  assign wr     = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[11:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      enable_q   <= 1'b0;
    end else begin
      // Software write wins over the increment
      if (wr && offset == TMR_MTIME) begin
        mtime_q <= apply_strobe(mtime_q, reg_req_i.wdata, reg_req_i.wstrb);
      end else if (enable_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr && offset == TMR_MTIMECMP) begin
        mtimecmp_q <= apply_strobe(mtimecmp_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && offset == TMR_CTRL && reg_req_i.wstrb[0]) begin
        enable_q <= reg_req_i.wdata[0];
      end
    end
  end

  // Level interrupt, one cycle behind the compare
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= enable_q && (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      TMR_MTIME:    reg_rsp_o.rdata = mtime_q;
      TMR_MTIMECMP: reg_rsp_o.rdata = mtimecmp_q;
      TMR_CTRL:     reg_rsp_o.rdata = {31'b0, enable_q};
      default:      reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_irq_o = irq_q;

endmodule

// File: hw/obi_to_reg.sv
/*
 * OBI to register-bus bridge
 * One access in flight, response returned one cycle after grant
 */
module obi_to_reg
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        xfer;

  // No new request while a response is still being returned
  always_comb begin
    reg_req_o.valid = obi_req_i.req & ~rvalid_q;
    reg_req_o.write = obi_req_i.we;
    reg_req_o.wstrb = obi_req_i.be;
    reg_req_o.addr  = obi_req_i.addr;
    reg_req_o.wdata = obi_req_i.wdata;
  end

  assign xfer = reg_req_o.valid & reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  // Writes and bus errors return zero
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rdata_q <= (reg_rsp_i.error || obi_req_i.we) ? '0 : reg_rsp_i.rdata;
    end
  end

  assign obi_resp_o.gnt    = xfer;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata  = rdata_q;

endmodule

// File: hw/pad_attribute.sv
/*
 * Pad attribute registers, one 16-bit word per pad
 */
module pad_attribute
  import ao_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  reg_req_t                 reg_req_i,
  output reg_rsp_t                 reg_rsp_o,
  output logic [NUM_PAD-1:0][15:0] pad_attributes_o
);

  localparam int unsigned PAD_W = (NUM_PAD > 1) ? $clog2(NUM_PAD) : 1;

  logic [NUM_PAD-1:0][15:0] pad_q;
  logic [11:0]              offset;
  logic [9:0]               word_idx;
  logic                     in_range;
  logic [PAD_W-1:0]         pad_sel;
  logic [31:0]              merged;

  assign offset   = reg_req_i.addr[11:0] - PAD_ATTR_BASE;
  assign word_idx = offset[11:2];
  assign in_range = (word_idx < NUM_PAD);
  assign pad_sel  = word_idx[PAD_W-1:0];

  // Only the low two byte lanes reach the attribute
  assign merged = apply_strobe({16'b0, pad_q[pad_sel]}, reg_req_i.wdata,
                               {2'b00, reg_req_i.wstrb[1:0]});

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pad_q <= '0;
    end else if (reg_req_i.valid && reg_req_i.write && in_range) begin
      pad_q[pad_sel] <= merged[15:0];
    end
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = in_range ? {16'b0, pad_q[pad_sel]} : '0;

  assign pad_attributes_o = pad_q;

endmodule

// File: hw/power_manager.sv
/*
 * CPU power manager
 * Isolates, gates and restores the CPU domain around core sleep
 */
module power_manager
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     core_sleep_i,
  input  logic     timer_irq_i,
  output logic     cpu_subsystem_powergate_switch_o,
  output logic     cpu_subsystem_rst_no
);

  localparam int unsigned CNT_W = $clog2(RESTORE_CYCLES + 1);

  pm_state_e   state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic        arm_q;
  logic [31:0] wake_cnt_q;
  logic        wake;
  logic        wr;
  logic [11:0] offset;

  assign wr     = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[11:0];

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    wake    = 1'b0;
    case (state_q)
      PM_ACTIVE: begin
        if (arm_q && core_sleep_i) begin
          state_d = PM_ISOLATE;
        end
      end
      PM_ISOLATE: state_d = PM_OFF;
      PM_OFF: begin
        if (timer_irq_i) begin
          state_d = PM_RESTORE;
          cnt_d   = CNT_W'(RESTORE_CYCLES - 1);
        end
      end
      default: begin
        if (cnt_q == '0) begin
          state_d = PM_ACTIVE;
          wake    = 1'b1;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= PM_ACTIVE;
      cnt_q      <= '0;
      arm_q      <= 1'b0;
      wake_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (wr && offset == PM_CTRL && reg_req_i.wstrb[0]) begin
        arm_q <= reg_req_i.wdata[0];
      end
      if (wake) begin
        wake_cnt_q <= wake_cnt_q + 32'd1;
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      PM_CTRL:       reg_rsp_o.rdata = {31'b0, arm_q};
      PM_STATUS:     reg_rsp_o.rdata = {30'b0, state_q};
      PM_WAKE_COUNT: reg_rsp_o.rdata = wake_cnt_q;
      default:       reg_rsp_o.rdata = '0;
    endcase
  end

  assign cpu_subsystem_rst_no             = (state_q == PM_ACTIVE);
  assign cpu_subsystem_powergate_switch_o = (state_q == PM_OFF);

endmodule

// File: hw/reg_demux.sv
/*
 * Register-bus demux for the always-on region
 * Decodes the 4 KiB slot and answers unmapped accesses with an error
 */
module reg_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t                     in_req_i,
  output reg_rsp_t                     in_rsp_o,
  output reg_req_t [NUM_AO_PERIPH-1:0] out_req_o,
  input  reg_rsp_t [NUM_AO_PERIPH-1:0] out_rsp_i
);

  logic                  hit;
  logic [SLOT_WIDTH-1:0] slot;

  // Upper half must match and bits 15:14 must be clear
  assign hit  = (in_req_i.addr[31:16] == AO_BASE_HI) && (in_req_i.addr[15:14] == 2'b00);
  assign slot = in_req_i.addr[13:12];

  always_comb begin
    for (int i = 0; i < NUM_AO_PERIPH; i++) begin
      out_req_o[i] = '0;
      if (hit && (slot == SLOT_WIDTH'(i))) begin
        out_req_o[i] = in_req_i;
      end
    end
  end

  always_comb begin
    if (hit) begin
      in_rsp_o = out_rsp_i[slot];
    end else begin
      in_rsp_o.ready = 1'b1;
      in_rsp_o.error = 1'b1;
      in_rsp_o.rdata = '0;
    end
  end

endmodule

// File: hw/soc_ctrl.sv
/*
 * System-control registers
 * Exit value and valid, boot-select readback and a scratch word
 */
module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;
  logic        boot_sel_q;
  logic        wr;
  logic [11:0] offset;

  assign wr     = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[11:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
      boot_sel_q   <= 1'b0;
    end else begin
      boot_sel_q <= boot_select_i;
      if (wr && offset == SOC_EXIT_VALID && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (wr && offset == SOC_EXIT_VALUE) begin
        exit_value_q <= apply_strobe(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && offset == SOC_SCRATCH) begin
        scratch_q <= apply_strobe(scratch_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      SOC_EXIT_VALID: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE: reg_rsp_o.rdata = exit_value_q;
      SOC_BOOT_SEL:   reg_rsp_o.rdata = {31'b0, boot_sel_q};
      SOC_SCRATCH:    reg_rsp_o.rdata = scratch_q;
      default:        reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// File: sim.f
hw/ao_periph_pkg.sv
hw/obi_to_reg.sv
hw/reg_demux.sv
hw/soc_ctrl.sv
hw/ao_timer.sv
hw/power_manager.sv
hw/pad_attribute.sv
hw/ao_peripheral_subsystem.sv
verif/tb_clk_gen.sv
verif/ao_peripheral_subsystem_sva.sv
verif/tb_ao_peripheral_subsystem.sv

// File: verif/ao_peripheral_subsystem_sva.sv
/*
 * Assertions for the always-on peripheral subsystem
 * OBI handshake, reset values and CPU power sequencing
 */
module ao_peripheral_subsystem_sva
  import ao_periph_pkg::*;
(
  input logic                     clk_i,
  input logic                     arst_n_i,
  input obi_req_t                 slave_req_i,
  input obi_resp_t                slave_resp_o,
  input logic                     core_sleep_i,
  input logic                     exit_valid_o,
  input logic                     rv_timer_irq_timer_o,
  input logic                     cpu_subsystem_powergate_switch_o,
  input logic                     cpu_subsystem_rst_no,
  input logic [NUM_PAD-1:0][15:0] pad_attributes_o
);

  int unsigned fail_cnt = 0;

  // Response exactly one cycle after the grant cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (slave_req_i.req && slave_resp_o.gnt) |=> slave_resp_o.rvalid)
    else begin $error("rvalid missing one cycle after grant"); fail_cnt++; end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slave_resp_o.rvalid |-> $past(slave_req_i.req && slave_resp_o.gnt))
    else begin $error("rvalid without a grant in the cycle before"); fail_cnt++; end

  assert property (@(posedge clk_i) slave_resp_o.gnt |-> slave_req_i.req)
    else begin $error("gnt without req"); fail_cnt++; end

  // Reset values still in place on the first edge after release
  assert property (@(posedge clk_i) $rose(arst_n_i) |->
    (!slave_resp_o.rvalid && !exit_valid_o && !rv_timer_irq_timer_o &&
     !cpu_subsystem_powergate_switch_o && cpu_subsystem_rst_no && pad_attributes_o == '0))
    else begin $error("outputs not at reset values"); fail_cnt++; end

  // Sleep entry, gating one cycle after isolation
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(cpu_subsystem_rst_no) |-> $past(core_sleep_i) ##1 $rose(cpu_subsystem_powergate_switch_o))
    else begin $error("power switch did not follow CPU reset"); fail_cnt++; end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(cpu_subsystem_powergate_switch_o) |-> $past(rv_timer_irq_timer_o)
      ##RESTORE_CYCLES $rose(cpu_subsystem_rst_no))
    else begin $error("wrong restore spacing before CPU reset release"); fail_cnt++; end

  assert property (@(posedge clk_i)
    !(cpu_subsystem_rst_no && cpu_subsystem_powergate_switch_o))
    else begin $error("CPU out of reset while power switch is on"); fail_cnt++; end

endmodule

bind ao_peripheral_subsystem ao_peripheral_subsystem_sva ao_sva_i (.*);

// File: verif/tb_ao_peripheral_subsystem.sv
/*
 * Testbench for the always-on peripheral subsystem
 * Register accesses over OBI, output checks and power-sequence stimulus
 */
module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                     clk;
  logic                     arst_n;
  obi_req_t                 slave_req;
  obi_resp_t                slave_resp;
  logic                     boot_select;
  logic                     core_sleep;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic                     timer_irq;
  logic                     pg_switch;
  logic                     cpu_rst_n;
  logic [NUM_PAD-1:0][15:0] pad_attr;

  logic                     gnt_q;
  int unsigned              cycle_cnt = 0;
  int unsigned              tb_errors = 0;
  int unsigned              tests_passed = 0;
  int unsigned              tests_failed = 0;
  int unsigned              errors_at_start;
  string                    test_name;
  integer                   seed = 86890;

  // Scoreboard
  logic [31:0]              sb_scratch;
  logic [31:0]              sb_mtimecmp;
  logic [15:0]              sb_pad [NUM_PAD];

  tb_clk_gen #(.PERIOD(20)) clk_gen_i (.clk_o(clk));

  ao_peripheral_subsystem dut (
    .clk_i                           (clk),
    .arst_n_i                        (arst_n),
    .slave_req_i                     (slave_req),
    .slave_resp_o                    (slave_resp),
    .boot_select_i                   (boot_select),
    .core_sleep_i                    (core_sleep),
    .exit_valid_o                    (exit_valid),
    .exit_value_o                    (exit_value),
    .rv_timer_irq_timer_o            (timer_irq),
    .cpu_subsystem_powergate_switch_o(pg_switch),
    .cpu_subsystem_rst_no            (cpu_rst_n),
    .pad_attributes_o                (pad_attr)
  );

  // Grant as seen at the clock edge
  always @(posedge clk) begin
    gnt_q <= slave_resp.gnt;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int unsigned total_errors();
    return tb_errors + dut.ao_sva_i.fail_cnt;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [1:0] slot, input logic [11:0] off);
    return {AO_BASE_HI, 2'b00, slot, off};
  endfunction

  // Expected value of a byte-enabled write
  function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  be);
    logic [31:0] res;
    for (int i = 0; i < 32; i++) begin
      res[i] = be[i / 8] ? new_val[i] : old_val[i];
    end
    return res;
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
      tb_errors++;
    end
  endtask

  task automatic obi_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned waited;
    waited = 0;
    rdata  = '0;
    @(negedge clk);
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = be;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!gnt_q && waited < 16);
    slave_req = '0;
    if (!gnt_q) begin
      $display("Error at time %0t: no grant for address %h", $time, addr);
      tb_errors++;
    end else begin
      waited = 0;
      while (!slave_resp.rvalid && waited < 4) begin
        @(negedge clk);
        waited++;
      end
      if (!slave_resp.rvalid) begin
        $display("Error at time %0t: no response for address %h", $time, addr);
        tb_errors++;
      end
      rdata = slave_resp.rdata;
    end
  endtask

  task automatic reg_write(input logic [1:0] slot, input logic [11:0] off,
                           input logic [31:0] data, input logic [3:0] be);
    logic [31:0] unused;
    obi_access(1'b1, be, reg_addr(slot, off), data, unused);
    expect_eq("write response data", unused, '0);
  endtask

  task automatic reg_read(input logic [1:0] slot, input logic [11:0] off,
                          output logic [31:0] data);
    obi_access(1'b0, 4'hF, reg_addr(slot, off), '0, data);
  endtask

  task automatic check_pads();
    for (int p = 0; p < NUM_PAD; p++) begin
      expect_eq($sformatf("pad_attributes_o[%0d]", p), {16'b0, pad_attr[p]}, {16'b0, sb_pad[p]});
    end
  endtask

  task automatic verify_scoreboard();
    logic [31:0] rd;
    reg_read(SOC_CTRL_IDX, SOC_SCRATCH, rd);
    expect_eq("SOC_SCRATCH", rd, sb_scratch);
    reg_read(TIMER_IDX, TMR_MTIMECMP, rd);
    expect_eq("TMR_MTIMECMP", rd, sb_mtimecmp);
    for (int p = 0; p < NUM_PAD; p++) begin
      reg_read(PAD_ATTRIBUTE_IDX, PAD_ATTR_BASE + 12'(4 * p), rd);
      expect_eq($sformatf("PAD_ATTR[%0d]", p), rd, {16'b0, sb_pad[p]});
    end
    check_pads();
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = total_errors();
  endtask

  task automatic end_test();
    if (total_errors() == errors_at_start) begin
      $display("[%0t] test %s: passed", $time, test_name);
      tests_passed++;
    end else begin
      $display("[%0t] test %s: FAILED", $time, test_name);
      tests_failed++;
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] rd;
    logic [31:0] merged;
    logic [3:0]  be;
    int unsigned n;

    slave_req   = '0;
    boot_select = 1'b0;
    core_sleep  = 1'b0;
    arst_n      = 1'b0;
    sb_scratch  = '0;
    sb_mtimecmp = '1;
    for (int p = 0; p < NUM_PAD; p++) begin
      sb_pad[p] = '0;
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    start_test("random_register_writes");
    check_pads();
    reg_read(TIMER_IDX, TMR_CTRL, rd);
    expect_eq("TMR_CTRL after reset", rd, '0);
    verify_scoreboard();
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      be   = 4'($random(seed));
      reg_write(SOC_CTRL_IDX, SOC_SCRATCH, data, be);
      sb_scratch = byte_merge(sb_scratch, data, be);
      data = $random(seed);
      be   = 4'($random(seed));
      reg_write(TIMER_IDX, TMR_MTIMECMP, data, be);
      sb_mtimecmp = byte_merge(sb_mtimecmp, data, be);
      for (int p = 0; p < NUM_PAD; p++) begin
        data = $random(seed);
        be   = 4'($random(seed));
        reg_write(PAD_ATTRIBUTE_IDX, PAD_ATTR_BASE + 12'(4 * p), data, be);
        // Only byte lanes 1:0 hold an attribute
        merged    = byte_merge({16'b0, sb_pad[p]}, data, {2'b00, be[1:0]});
        sb_pad[p] = merged[15:0];
        check_pads();
      end
      verify_scoreboard();
    end
    end_test();

    start_test("unmapped_access");
    obi_access(1'b0, 4'hF, {AO_BASE_HI, 2'b01, SOC_CTRL_IDX, SOC_SCRATCH}, '0, rd);
    expect_eq("read with bits 15:14 set", rd, '0);
    obi_access(1'b0, 4'hF, {16'h3000, 2'b00, SOC_CTRL_IDX, SOC_SCRATCH}, '0, rd);
    expect_eq("read with wrong upper half", rd, '0);
    obi_access(1'b1, 4'hF, {AO_BASE_HI, 2'b10, SOC_CTRL_IDX, SOC_SCRATCH}, $random(seed), rd);
    obi_access(1'b1, 4'hF, {16'h3000, 2'b00, TIMER_IDX, TMR_MTIMECMP}, $random(seed), rd);
    obi_access(1'b1, 4'hF, {16'h3000, 2'b00, PAD_ATTRIBUTE_IDX, PAD_ATTR_BASE},
               $random(seed), rd);
    verify_scoreboard();
    end_test();

    start_test("exit_and_boot_select");
    expect_eq("exit_valid_o before write", {31'b0, exit_valid}, '0);
    data = $random(seed);
    reg_write(SOC_CTRL_IDX, SOC_EXIT_VALUE, data, 4'hF);
    reg_write(SOC_CTRL_IDX, SOC_EXIT_VALID, 32'd1, 4'hF);
    expect_eq("exit_value_o", exit_value, data);
    expect_eq("exit_valid_o", {31'b0, exit_valid}, 32'd1);
    @(negedge clk);
    boot_select = 1'b1;
    reg_read(SOC_CTRL_IDX, SOC_BOOT_SEL, rd);
    expect_eq("SOC_BOOT_SEL high", rd, 32'd1);
    @(negedge clk);
    boot_select = 1'b0;
    reg_read(SOC_CTRL_IDX, SOC_BOOT_SEL, rd);
    expect_eq("SOC_BOOT_SEL low", rd, '0);
    end_test();

    start_test("timer_compare_irq");
    reg_write(TIMER_IDX, TMR_MTIMECMP, 32'd12, 4'hF);
    reg_write(TIMER_IDX, TMR_MTIME, '0, 4'hF);
    reg_write(TIMER_IDX, TMR_CTRL, 32'd1, 4'hF);
    for (int c = 1; c <= 14; c++) begin
      @(negedge clk);
      if (c < 12) begin
        expect_eq("timer irq before compare", {31'b0, timer_irq}, '0);
      end
    end
    expect_eq("timer irq after compare", {31'b0, timer_irq}, 32'd1);
    reg_write(TIMER_IDX, TMR_MTIMECMP, 32'h8000_0000, 4'hF);
    sb_mtimecmp = 32'h8000_0000;
    @(negedge clk);
    expect_eq("timer irq after compare moved up", {31'b0, timer_irq}, '0);
    end_test();

    start_test("power_sequence");
    reg_write(TIMER_IDX, TMR_CTRL, '0, 4'hF);
    reg_write(TIMER_IDX, TMR_MTIME, '0, 4'hF);
    reg_write(TIMER_IDX, TMR_MTIMECMP, 32'd24, 4'hF);
    sb_mtimecmp = 32'd24;
    reg_write(POWER_MANAGER_IDX, PM_CTRL, 32'd1, 4'hF);
    @(negedge clk);
    core_sleep = 1'b1;
    n = 0;
    while (cpu_rst_n && n < 8) begin
      @(negedge clk);
      n++;
    end
    expect_eq("cpu reset after sleep", {31'b0, cpu_rst_n}, '0);
    @(negedge clk);
    core_sleep = 1'b0;
    expect_eq("power switch after isolation", {31'b0, pg_switch}, 32'd1);
    reg_read(POWER_MANAGER_IDX, PM_STATUS, rd);
    expect_eq("PM_STATUS while off", rd, 32'(PM_OFF));
    reg_write(TIMER_IDX, TMR_CTRL, 32'd1, 4'hF);
    n = 0;
    while (pg_switch && n < 64) begin
      @(negedge clk);
      n++;
    end
    expect_eq("power switch after timer wake-up", {31'b0, pg_switch}, '0);
    n = 0;
    while (!cpu_rst_n && n < 16) begin
      @(negedge clk);
      n++;
    end
    expect_eq("restore cycles", n, RESTORE_CYCLES);
    reg_read(POWER_MANAGER_IDX, PM_WAKE_COUNT, rd);
    expect_eq("PM_WAKE_COUNT", rd, 32'd1);
    reg_write(TIMER_IDX, TMR_CTRL, '0, 4'hF);
    reg_write(POWER_MANAGER_IDX, PM_CTRL, '0, 4'hF);
    @(negedge clk);
    core_sleep = 1'b1;
    repeat (8) begin
      @(negedge clk);
      expect_eq("cpu reset with arm cleared", {31'b0, cpu_rst_n}, 32'd1);
      expect_eq("power switch with arm cleared", {31'b0, pg_switch}, '0);
    end
    core_sleep = 1'b0;
    reg_read(POWER_MANAGER_IDX, PM_STATUS, rd);
    expect_eq("PM_STATUS after ignored sleep", rd, 32'(PM_ACTIVE));
    end_test();

    start_test("pad_attribute_outputs");
    for (int p = 0; p < NUM_PAD; p++) begin
      data = $random(seed);
      reg_write(PAD_ATTRIBUTE_IDX, PAD_ATTR_BASE + 12'(4 * p), data, 4'hF);
      sb_pad[p] = data[15:0];
      check_pads();
    end
    reg_write(PAD_ATTRIBUTE_IDX, PAD_ATTR_BASE + 12'(4 * NUM_PAD), 32'hFFFF_FFFF, 4'hF);
    reg_read(PAD_ATTRIBUTE_IDX, PAD_ATTR_BASE + 12'(4 * NUM_PAD), rd);
    expect_eq("pad word beyond NUM_PAD", rd, '0);
    verify_scoreboard();
    end_test();

    $display("Tests: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_clk_gen.sv
/*
 * Testbench clock generator
 */
module tb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic clk_o
);

  initial clk_o = 1'b0;
  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule
